// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_dac_ramp
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# verdict from the log, a crashed or stopped run also fails
run: compile
	./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Test failed" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dac_cmd_pkg.sv
package dac_cmd_pkg;

  localparam int frame_bits = 24;  // serial word length

  // 3-bit command field of the DAC input shift register
  typedef enum logic [2:0] {
    cmd_write_update = 3'b011,  // write input reg, update output
    cmd_sw_reset     = 3'b101,
    cmd_ldac_setup   = 3'b110
  } dac_cmd_e;

  // only the two ramp channels are ever addressed
  typedef enum logic [2:0] {
    addr_ch_a = 3'b000,
    addr_ch_b = 3'b001
  } dac_addr_e;

  // frame as shifted out, MSB first
  typedef struct packed {
    logic [1:0]  dont_care;
    dac_cmd_e    cmd;
    dac_addr_e   addr;
    logic [15:0] data;  // ramp words use the upper byte only
  } frame_t;

  localparam logic [15:0] sw_reset_data = 16'h0001;
  localparam logic [15:0] ldac_data     = 16'h000F;  // ldac pin ignored on all channels

endpackage

// File: dac_frame_rom.sv
`timescale 1ns/1ps

module dac_frame_rom (
  input  logic                     clk,
  input  seq_ctrl_pkg::frame_sel_e frame_sel,
  input  logic [7:0]               ramp_a,
  input  logic [7:0]               ramp_b,
  output dac_cmd_pkg::frame_t      frame
);
  import dac_cmd_pkg::*;
  import seq_ctrl_pkg::*;

  frame_t frame_d;

  always_comb begin
    frame_d.dont_care = 2'b00;
    case (frame_sel)
      fr_reset: begin
        frame_d.cmd  = cmd_sw_reset;
        frame_d.addr = addr_ch_a;  // address ignored by the DAC here
        frame_d.data = sw_reset_data;
      end
      fr_ldac: begin
        frame_d.cmd  = cmd_ldac_setup;
        frame_d.addr = addr_ch_a;
        frame_d.data = ldac_data;
      end
      fr_ch_a: begin
        frame_d.cmd  = cmd_write_update;
        frame_d.addr = addr_ch_a;
        frame_d.data = {ramp_a, 8'h00};  // 8-bit ramp in the top byte
      end
      default: begin
        frame_d.cmd  = cmd_write_update;
        frame_d.addr = addr_ch_b;
        frame_d.data = {ramp_b, 8'h00};
      end
    endcase
  end

  always_ff @(posedge clk) begin
    frame <= frame_d;
  end

endmodule

// File: dac_ramp_cases.txt
# op value: B host byte, Y tx_busy cycles, F expected frame, K expected ack, N end of test
# frame hex: 2 spare bits, 3-bit command, 3-bit address, 16-bit data
B 68
K 6B
F 280001
F 30000F
N 1
F 181500
F 19A100
F 181600
F 19A000
N 2
B 73
K 6B
N 3
B 75
B 16
B 64
B 14
B 68
K 6B
F 280001
F 30000F
F 181400
F 191600
F 181500
F 191500
F 181600
F 191400
F 181700
F 191300
F 181400
F 191600
N 4
Y 30
B 73
K 6B
Y 30
B 68
K 6B
F 280001
F 30000F
F 181400
F 191600
F 181500
N 5

// File: dac_ramp_properties.sv
`timescale 1ns/1ps

module dac_ramp_properties #(
  parameter int cs_gap = 3
) (
  input logic clk,
  input logic rst,
  input logic cs,
  input logic sclk,
  input logic new_rx_data,
  input logic new_tx_data
);

  int cs_high_cnt;  // cycles cs has been high up to cs_gap

  always_ff @(posedge clk) begin
    if (rst || !cs) begin
      cs_high_cnt <= 0;
    end else if (cs_high_cnt < cs_gap) begin
      cs_high_cnt <= cs_high_cnt + 1;
    end
  end

  sclk_idle_a: assert property (@(posedge clk) disable iff (rst) cs |-> !sclk)
    else $error("sclk high while cs is high");

  cs_gap_a: assert property (@(posedge clk) disable iff (rst)
    $fell(cs) |-> cs_high_cnt >= cs_gap)
    else $error("cs high for fewer than %0d cycles", cs_gap);

  // one ack strobe per command
  ack_strobe_a: assert property (@(posedge clk) disable iff (rst)
    new_tx_data && !new_rx_data |=> !new_tx_data)
    else $error("new_tx_data held for more than one cycle");

endmodule

bind dac_ramp_top dac_ramp_properties #(
  .cs_gap(cs_gap)
) dac_ramp_properties_i (
  .clk        (clk),
  .rst        (rst),
  .cs         (cs),
  .sclk       (sclk),
  .new_rx_data(new_rx_data),
  .new_tx_data(new_tx_data)
);

// File: dac_ramp_sequencer.sv
`timescale 1ns/1ps

module dac_ramp_sequencer #(
  parameter int cs_gap = 3  // cs high time between frames
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic [7:0]               rx_data,
  input  logic                     new_rx_data,
  input  logic                     tx_busy,
  output logic [7:0]               tx_data,
  output logic                     new_tx_data,
  input  logic [7:0]               up_limit,
  input  logic [7:0]               down_limit,
  input  logic                     spi_done,
  output logic                     spi_start,
  output logic                     stop_req,
  output logic                     cs,
  output seq_ctrl_pkg::frame_sel_e frame_sel,
  output logic [7:0]               ramp_a,
  output logic [7:0]               ramp_b
);
  import seq_ctrl_pkg::*;

  localparam int gap_w = $clog2(cs_gap + 1);

  seq_state_e       state;
  ramp_ch_e         ch;
  logic [gap_w-1:0] gap_cnt;
  logic             gap_run;     // cs high, gap counting
  logic             start_arm;   // cs just fell
  logic             ack_pend;
  logic             skip_value;  // byte after u/d is a value
  logic             cmd_valid;
  logic             start_cmd;
  logic             frame_end;

  assign cmd_valid = new_rx_data && !skip_value;
  assign start_cmd = cmd_valid && (rx_data == host_start) && (state == st_idle);
  assign stop_req  = cmd_valid && (rx_data == host_stop);  // also aborts the master
  assign frame_end = spi_done && (state != st_idle);

  assign tx_data     = ack_byte;
  assign new_tx_data = ack_pend && !tx_busy;

  always_ff @(posedge clk) begin
    if (rst) begin
      skip_value <= 1'b0;
    end else if (new_rx_data) begin
      skip_value <= !skip_value && (rx_data == host_up || rx_data == host_down);
    end
  end

  // a single pending ack, a newer command simply re-arms it
  always_ff @(posedge clk) begin
    if (rst) begin
      ack_pend <= 1'b0;
    end else begin
      if (new_tx_data) ack_pend <= 1'b0;
      if (start_cmd || stop_req) ack_pend <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= st_idle;
      ch        <= ch_a;
      frame_sel <= fr_reset;
      cs        <= 1'b1;
      gap_run   <= 1'b0;
      gap_cnt   <= '0;
      start_arm <= 1'b0;
      spi_start <= 1'b0;
    end else if (stop_req) begin
      state     <= st_idle;
      cs        <= 1'b1;
      gap_run   <= 1'b0;
      start_arm <= 1'b0;
      spi_start <= 1'b0;
    end else begin
      spi_start <= start_arm;  // one cycle after cs falls
      start_arm <= 1'b0;
      if (gap_run) begin
        if (gap_cnt == gap_w'(cs_gap - 1)) begin
          cs        <= 1'b0;
          gap_run   <= 1'b0;
          start_arm <= 1'b1;
        end else begin
          gap_cnt <= gap_cnt + 1'b1;
        end
      end
      if (start_cmd) begin
        state     <= st_sw_reset;
        ch        <= ch_a;
        frame_sel <= fr_reset;
        gap_run   <= 1'b1;
        gap_cnt   <= '0;
      end else if (frame_end) begin
        cs      <= 1'b1;
        gap_run <= 1'b1;
        gap_cnt <= '0;
        case (state)
          st_sw_reset: begin
            state     <= st_ldac_setup;
            frame_sel <= fr_ldac;
          end
          st_ldac_setup: begin
            state     <= st_set_channel;
            ch        <= ch_a;
            frame_sel <= fr_ch_a;
          end
          st_set_channel: begin
            ch        <= (ch == ch_a) ? ch_b : ch_a;
            frame_sel <= (ch == ch_a) ? fr_ch_b : fr_ch_a;
          end
          default: state <= st_idle;
        endcase
      end
    end
  end

  // ramps step after their own frame has gone out
  always_ff @(posedge clk) begin
    if (start_cmd) begin
      ramp_a <= down_limit;
      ramp_b <= up_limit;
    end else if (frame_end && state == st_set_channel) begin
      if (ch == ch_a) begin
        ramp_a <= (ramp_a > up_limit) ? down_limit : ramp_a + 8'd1;
      end else begin
        ramp_b <= (ramp_b < down_limit) ? up_limit : ramp_b - 8'd1;
      end
    end
  end

endmodule

// File: dac_ramp_top.sv
`timescale 1ns/1ps

module dac_ramp_top #(
  parameter int         clk_div         = 2,
  parameter logic [7:0] up_limit_init   = 8'd161,
  parameter logic [7:0] down_limit_init = 8'd21,
  parameter int         cs_gap          = 3
) (
  input  logic       clk,
  input  logic       rst,
  input  logic [7:0] rx_data,
  input  logic       new_rx_data,
  input  logic       tx_busy,
  output logic [7:0] tx_data,
  output logic       new_tx_data,
  output logic       sclk,
  output logic       mosi,
  output logic       cs
);
  import dac_cmd_pkg::*;
  import seq_ctrl_pkg::*;

  logic [7:0] up_limit;
  logic [7:0] down_limit;
  logic [7:0] ramp_a;
  logic [7:0] ramp_b;
  logic       spi_start;
  logic       spi_done;
  logic       stop_req;
  frame_sel_e frame_sel;
  frame_t     frame;

  ramp_limit_regs #(
    .up_limit_init  (up_limit_init),
    .down_limit_init(down_limit_init)
  ) ramp_limit_regs_i (
    .clk        (clk),
    .rst        (rst),
    .rx_data    (rx_data),
    .new_rx_data(new_rx_data),
    .up_limit   (up_limit),
    .down_limit (down_limit)
  );

  dac_ramp_sequencer #(
    .cs_gap(cs_gap)
  ) dac_ramp_sequencer_i (
    .clk        (clk),
    .rst        (rst),
    .rx_data    (rx_data),
    .new_rx_data(new_rx_data),
    .tx_busy    (tx_busy),
    .tx_data    (tx_data),
    .new_tx_data(new_tx_data),
    .up_limit   (up_limit),
    .down_limit (down_limit),
    .spi_done   (spi_done),
    .spi_start  (spi_start),
    .stop_req   (stop_req),
    .cs         (cs),
    .frame_sel  (frame_sel),
    .ramp_a     (ramp_a),
    .ramp_b     (ramp_b)
  );

  dac_frame_rom dac_frame_rom_i (
    .clk      (clk),
    .frame_sel(frame_sel),
    .ramp_a   (ramp_a),
    .ramp_b   (ramp_b),
    .frame    (frame)
  );

  dac_spi_master #(
    .clk_div(clk_div)
  ) dac_spi_master_i (
    .clk  (clk),
    .rst  (rst),
    .start(spi_start),
    .abort(stop_req),
    .frame(frame),
    .sclk (sclk),
    .mosi (mosi),
    .done (spi_done),
    .busy ()  // sequencer paces frames on done
  );

endmodule

// File: dac_spi_master.sv
`timescale 1ns/1ps

module dac_spi_master #(
  parameter int clk_div = 2  // sclk half period in clk cycles
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                start,
  input  logic                abort,
  input  dac_cmd_pkg::frame_t frame,
  output logic                sclk,
  output logic                mosi,
  output logic                done,
  output logic                busy
);
  import dac_cmd_pkg::*;

  localparam int div_w = $clog2(clk_div + 1);
  localparam int cnt_w = $clog2(frame_bits);

  logic [frame_bits-1:0] shreg;
  logic [div_w-1:0]      div_cnt;
  logic [cnt_w-1:0]      bit_cnt;
  logic                  tick;   // sclk toggles this cycle
  logic                  launch;

  assign launch = start && !busy;
  assign tick   = busy && (div_cnt == div_w'(clk_div - 1));
  assign mosi   = shreg[frame_bits-1];  // msb first

  always_ff @(posedge clk) begin
    if (rst || abort) begin
      busy    <= 1'b0;
      sclk    <= 1'b0;
      done    <= 1'b0;
      div_cnt <= '0;
      bit_cnt <= '0;
    end else begin
      done <= 1'b0;
      if (launch) begin
        busy    <= 1'b1;
        sclk    <= 1'b0;
        div_cnt <= '0;
        bit_cnt <= '0;
      end else if (busy) begin
        div_cnt <= tick ? '0 : div_cnt + 1'b1;
        if (tick) begin
          sclk <= !sclk;
          if (sclk) begin  // falling edge
            if (bit_cnt == cnt_w'(frame_bits - 1)) begin
              busy <= 1'b0;  // sclk lands low here
              done <= 1'b1;
            end else begin
              bit_cnt <= bit_cnt + 1'b1;
            end
          end
        end
      end
    end
  end

  // first bit is on mosi before the first rising edge
  always_ff @(posedge clk) begin
    if (launch) begin
      shreg <= frame;
    end else if (tick && sclk) begin
      shreg <= {shreg[frame_bits-2:0], 1'b0};
    end
  end

endmodule

// File: ramp_limit_regs.sv
`timescale 1ns/1ps

module ramp_limit_regs #(
  parameter logic [7:0] up_limit_init   = 8'd161,
  parameter logic [7:0] down_limit_init = 8'd21
) (
  input  logic       clk,
  input  logic       rst,
  input  logic [7:0] rx_data,
  input  logic       new_rx_data,
  output logic [7:0] up_limit,
  output logic [7:0] down_limit
);
  import seq_ctrl_pkg::*;

  typedef enum logic {
    cap_cmd,   // looking for u or d
    cap_value  // next byte is the limit value
  } cap_state_e;

  cap_state_e cap_state;
  logic       sel_up;  // which limit the pending value goes to

  always_ff @(posedge clk) begin
    if (rst) begin
      cap_state  <= cap_cmd;
      sel_up     <= 1'b0;
      up_limit   <= up_limit_init;
      down_limit <= down_limit_init;
    end else if (new_rx_data) begin
      case (cap_state)
        cap_cmd: begin
          if (rx_data == host_up || rx_data == host_down) begin
            cap_state <= cap_value;
            sel_up    <= (rx_data == host_up);
          end
        end
        cap_value: begin
          // value byte is taken as is, even if it looks like a command
          if (sel_up) begin
            up_limit <= rx_data;
          end else begin
            down_limit <= rx_data;
          end
          cap_state <= cap_cmd;
        end
        default: cap_state <= cap_cmd;
      endcase
    end
  end

endmodule

// File: seq_ctrl_pkg.sv
package seq_ctrl_pkg;

  typedef enum logic [1:0] {
    st_idle,
    st_sw_reset,
    st_ldac_setup,
    st_set_channel
  } seq_state_e;

  typedef enum logic {
    ch_a,
    ch_b
  } ramp_ch_e;

  // ascii command bytes from the host link
  typedef enum logic [7:0] {
    host_start = 8'h68,  // "h"
    host_stop  = 8'h73,  // "s"
    host_up    = 8'h75,  // "u"
    host_down  = 8'h64   // "d"
  } host_cmd_e;

  localparam logic [7:0] ack_byte = 8'h6B;  // "k"

  // frame index between sequencer and frame lookup
  typedef enum logic [1:0] {
    fr_reset,
    fr_ldac,
    fr_ch_a,
    fr_ch_b
  } frame_sel_e;

endpackage

// File: sources.f
dac_cmd_pkg.sv
seq_ctrl_pkg.sv
ramp_limit_regs.sv
dac_frame_rom.sv
dac_spi_master.sv
dac_ramp_sequencer.sv
dac_ramp_top.sv
dac_ramp_properties.sv
tb_dac_ramp.sv

// File: tb_dac_ramp.sv
`timescale 1ns/1ps

module tb_dac_ramp;
  import dac_cmd_pkg::*;

  localparam int clk_div    = 2;
  localparam int cs_gap     = 3;
  localparam int frame_wait = 64 * clk_div + 4 * cs_gap + 16;  // one frame plus margin
  localparam int ack_wait   = 200;

  logic       clk         = 1'b0;
  logic       rst         = 1'b1;
  logic [7:0] rx_data     = 8'h00;
  logic       new_rx_data = 1'b0;
  logic       tx_busy     = 1'b0;
  logic [7:0] tx_data;
  logic       new_tx_data;
  logic       sclk;
  logic       mosi;
  logic       cs;

  frame_t      frame_q[$];  // frames seen on the serial bus
  logic [7:0]  ack_q[$];
  byte         ops[$];
  logic [31:0] args[$];

  logic [23:0] shift      = '0;
  int          nbits      = 0;
  int          cycle      = 0;
  int          busy_until = 0;
  integer      seed       = 32'hc49;
  int          pass_cnt   = 0;
  int          err_cnt    = 0;
  int          test_err   = 0;
  bit          loaded     = 1'b0;

  dac_ramp_top #(
    .clk_div        (clk_div),
    .up_limit_init  (8'd161),
    .down_limit_init(8'd21),
    .cs_gap         (cs_gap)
  ) dac_ramp_top_i (
    .clk        (clk),
    .rst        (rst),
    .rx_data    (rx_data),
    .new_rx_data(new_rx_data),
    .tx_busy    (tx_busy),
    .tx_data    (tx_data),
    .new_tx_data(new_tx_data),
    .sclk       (sclk),
    .mosi       (mosi),
    .cs         (cs)
  );

  always #10 clk = ~clk;

  // tx_busy stays high through the requested window
  always @(negedge clk) begin
    tx_busy = (cycle < busy_until);
    cycle++;
  end

  // frames cut short by a stop are dropped
  always @(posedge sclk or posedge cs) begin
    if (cs) begin
      if (nbits == frame_bits) frame_q.push_back(shift);
      nbits = 0;
    end else begin
      shift = {shift[22:0], mosi};
      nbits++;
    end
  end

  always @(posedge clk) begin
    if (new_tx_data) begin
      if (tx_busy) begin
        $display("time %0d ns: acknowledge sent while tx_busy was high", $time);
        count_error();
      end
      ack_q.push_back(tx_data);
    end
  end

  task automatic count_error();
    err_cnt++;
    test_err++;
  endtask

  task automatic check_frame(input frame_t got, input frame_t exp);
    if (got !== exp) begin
      $display("MISMATCH time %0d ns: frame got %06h expected %06h", $time, got, exp);
      count_error();
    end else begin
      pass_cnt++;
    end
  endtask

  task automatic check_ack(input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      $display("MISMATCH time %0d ns: ack got %02h expected %02h", $time, got, exp);
      count_error();
    end else begin
      pass_cnt++;
    end
  endtask

  task automatic send_byte(input logic [7:0] value);
    int gap;
    gap = $random(seed) & 7;  // idle gap 0..7 cycles
    repeat (gap) @(negedge clk);
    rx_data     = value;
    new_rx_data = 1'b1;
    @(negedge clk);
    new_rx_data = 1'b0;
  endtask

  task automatic hold_busy(input int cycles);
    @(posedge clk);
    busy_until = cycle + cycles;
    @(negedge clk);
  endtask

  task automatic expect_frame(input frame_t exp);
    int waited;
    waited = 0;
    while (frame_q.size() == 0 && waited < frame_wait) begin
      @(negedge clk);
      waited++;
    end
    if (frame_q.size() == 0) begin
      $display("time %0d ns: no frame arrived within %0d cycles", $time, frame_wait);
      count_error();
    end else begin
      check_frame(frame_q.pop_front(), exp);
    end
  endtask

  task automatic expect_ack(input logic [7:0] exp);
    int waited;
    waited = 0;
    while (ack_q.size() == 0 && waited < ack_wait) begin
      @(negedge clk);
      waited++;
    end
    if (ack_q.size() == 0) begin
      $display("time %0d ns: no acknowledge arrived within %0d cycles", $time, ack_wait);
      count_error();
    end else begin
      check_ack(ack_q.pop_front(), exp);
    end
  endtask

  task automatic end_test(input int test_no);
    if (test_err == 0) begin
      $display("test %0d: ok", test_no);
    end else begin
      $display("test %0d: %0d errors", test_no, test_err);
    end
    test_err = 0;
    // leftovers of a running sequence belong to no later test
    frame_q.delete();
    ack_q.delete();
  endtask

  task automatic run_op(input byte op, input logic [31:0] arg);
    case (op)
      "B": send_byte(arg[7:0]);
      "Y": hold_busy(arg);
      "F": expect_frame(arg[23:0]);
      "K": expect_ack(arg[7:0]);
      "N": end_test(arg);
      default: begin
        $display("unknown operation %c in cases file", op);
        count_error();
      end
    endcase
  endtask

  initial begin
    int          fd;
    string       line;
    byte         opc;
    logic [31:0] val;
    fd = $fopen("dac_ramp_cases.txt", "r");
    if (fd == 0) begin
      $display("cannot open cases file dac_ramp_cases.txt");
      count_error();
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() > 0 && line[0] != "#" && $sscanf(line, "%c %h", opc, val) == 2) begin
          ops.push_back(opc);
          args.push_back(val);
        end
      end
      $fclose(fd);
    end
    loaded = 1'b1;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    foreach (ops[i]) run_op(ops[i], args[i]);
    $display("closing: %0d checks passed, %0d errors", pass_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // watchdog scaled by the number of case lines
  initial begin
    int limit_ns;
    wait (loaded);
    limit_ns = ops.size() * 60 * clk_div * 20;
    #(limit_ns);
    $display("watchdog: cases did not complete within %0d ns", limit_ns);
    $display("Test failed");
    $finish;
  end

endmodule
